//--- design/rng_defs.svh
// Shared sizes and LCG constants for the RNG hub, included by any file that needs them.
`ifndef RNG_DEFS_SVH
`define RNG_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hub size.
`define RNG_NUM_CHANNELS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Generator step x' = A*x + C mod 2^32.
`define RNG_LCG_A        32'd1664525
`define RNG_LCG_C        32'd1013904223
`define RNG_RESET_SEED   32'd123456789

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buffering per channel.
`define RNG_REQ_DEPTH    2 // Also the client's starting request credits.
`define RNG_RSP_DEPTH    2
`define RNG_RSP_CREDITS  2 // Client receive buffer size.

`endif

//--- design/rng_op_pkg.sv
// Client command set of the RNG hub, imported by blocks that decode commands.
`default_nettype none

package rng_op_pkg;

    // Client command opcode.
    typedef enum logic [0:0] {
        OP_NEXT = 1'b0, // Return the next word.
        OP_SEED = 1'b1  // Load a new state, no response.
    } rng_op_t;

endpackage

`default_nettype wire

//--- design/rng_ctrl_pkg.sv
// Internal control types of the RNG hub, for channel indices and credit counts.
`default_nettype none

`include "rng_defs.svh"

package rng_ctrl_pkg;

    // Index of one client channel.
    typedef logic [$clog2(`RNG_NUM_CHANNELS)-1:0] chan_idx_t;

    // Credit counters and FIFO fill levels.
    typedef logic [2:0] credit_t;

endpackage

`default_nettype wire

//--- design/lcg_mul_lo.sv
// Low 32 bits of an unsigned 32x32 product, summed in a partial-product adder tree.
`timescale 1ns/100ps
`default_nettype none

module lcg_mul_lo (
    input  wire logic [31:0] multiplicand,
    input  wire logic [31:0] multiplier,
    output logic      [31:0] product_lo
);

    logic [31:0] partial [32];
    logic [31:0] level1  [16];
    logic [31:0] level2  [8];
    logic [31:0] level3  [4];
    logic [31:0] level4  [2];
    logic [31:0] level5  [1];

    // One row per multiplier bit, already shifted and cut to 32 bits.
    for (genvar i = 0; i < 32; i++) begin : gen_partial
        assign partial[i] = (multiplicand & {32{multiplier[i]}}) << i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Binary adder tree. Carries past bit 31 drop out.
    for (genvar i = 0; i < 16; i++) begin : gen_level1
        assign level1[i] = partial[2*i] + partial[2*i+1];
    end

    for (genvar i = 0; i < 8; i++) begin : gen_level2
        assign level2[i] = level1[2*i] + level1[2*i+1];
    end

    for (genvar i = 0; i < 4; i++) begin : gen_level3
        assign level3[i] = level2[2*i] + level2[2*i+1];
    end

    for (genvar i = 0; i < 2; i++) begin : gen_level4
        assign level4[i] = level3[2*i] + level3[2*i+1];
    end

    for (genvar i = 0; i < 1; i++) begin : gen_level5
        assign level5[i] = level4[2*i] + level4[2*i+1];
    end

    assign product_lo = level5[0];

endmodule

`default_nettype wire

//--- design/lcg_core.sv
// Shared LCG state register, stepped or reseeded by the arbiter each cycle.
`timescale 1ns/100ps
`default_nettype none

`include "rng_defs.svh"

module lcg_core (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        step,
    input  wire logic        load,
    input  wire logic [31:0] load_value,
    output logic      [31:0] next_value
);

    logic [31:0] state;
    logic [31:0] product_lo;

    lcg_mul_lo i_mul (
        .multiplicand (`RNG_LCG_A),
        .multiplier   (state),
        .product_lo   (product_lo)
    );

    assign next_value = product_lo + `RNG_LCG_C; // Word handed to the granted channel.

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= `RNG_RESET_SEED;
        end else if (load) begin
            state <= load_value;
        end else if (step) begin
            state <= next_value;
        end
    end

endmodule

`default_nettype wire

//--- design/rng_arbiter.sv
// Round-robin arbiter giving the generator to one channel per cycle.
`timescale 1ns/100ps
`default_nettype none

`include "rng_defs.svh"

module rng_arbiter (
    input  wire logic                                         clock,
    input  wire logic                                         reset,
    input  wire logic                [`RNG_NUM_CHANNELS-1:0]  arb_req,
    input  wire rng_op_pkg::rng_op_t [`RNG_NUM_CHANNELS-1:0]  arb_op,
    input  wire logic [`RNG_NUM_CHANNELS-1:0][31:0]           arb_seed,
    output logic                     [`RNG_NUM_CHANNELS-1:0]  grant,
    output logic                                              step,
    output logic                                              load,
    output logic                     [31:0]                   load_value
);

    import rng_op_pkg::*;
    import rng_ctrl_pkg::*;

    chan_idx_t pointer;
    chan_idx_t winner;
    logic      found;

    // Channel at a given distance past the pointer.
    function automatic chan_idx_t rr_index(input chan_idx_t base, input int offset);
        int sum;
        sum = int'(base) + offset;
        return chan_idx_t'(sum % `RNG_NUM_CHANNELS);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // First requester at or after the pointer.
    always_comb begin
        found  = 1'b0;
        winner = pointer;
        grant  = '0;
        for (int k = 0; k < `RNG_NUM_CHANNELS; k++) begin
            if (!found && arb_req[rr_index(pointer, k)]) begin
                found  = 1'b1;
                winner = rr_index(pointer, k);
            end
        end
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    assign step       = found && (arb_op[winner] == OP_NEXT);
    assign load       = found && (arb_op[winner] == OP_SEED);
    assign load_value = arb_seed[winner];

    always_ff @(posedge clock) begin
        if (reset) begin
            pointer <= '0;
        end else if (found) begin
            pointer <= (winner == chan_idx_t'(`RNG_NUM_CHANNELS - 1)) ? '0
                                                                       : winner + chan_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- design/rng_channel.sv
// One client channel of the hub with request and response FIFOs and credit flow control.
`timescale 1ns/100ps
`default_nettype none

`include "rng_defs.svh"

module rng_channel (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic                req_valid,
    input  wire rng_op_pkg::rng_op_t req_op,
    input  wire logic         [31:0] req_seed,
    output logic                     req_credit,
    output logic                     rsp_valid,
    output logic              [31:0] rsp_data,
    input  wire logic                rsp_credit,
    output logic                     arb_req,
    output rng_op_pkg::rng_op_t      arb_op,
    output logic              [31:0] arb_seed,
    input  wire logic                grant,
    input  wire logic         [31:0] next_value
);

    import rng_op_pkg::*;
    import rng_ctrl_pkg::*;

    localparam int REQ_AW = $clog2(`RNG_REQ_DEPTH);
    localparam int RSP_AW = $clog2(`RNG_RSP_DEPTH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request FIFO of op/seed pairs.
    rng_op_t           req_op_mem   [`RNG_REQ_DEPTH];
    logic       [31:0] req_seed_mem [`RNG_REQ_DEPTH];
    logic [REQ_AW-1:0] req_wr_ptr;
    logic [REQ_AW-1:0] req_rd_ptr;
    credit_t           req_count;
    logic              req_push;
    logic              req_pop;

    assign req_push = req_valid; // Client only sends while holding a credit.
    assign req_pop  = grant;
    assign arb_op   = req_op_mem[req_rd_ptr];
    assign arb_seed = req_seed_mem[req_rd_ptr];

    always_ff @(posedge clock) begin
        if (req_push) begin
            req_op_mem[req_wr_ptr]   <= req_op;
            req_seed_mem[req_wr_ptr] <= req_seed;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            req_wr_ptr <= '0;
            req_rd_ptr <= '0;
            req_count  <= '0;
            req_credit <= 1'b0;
        end else begin
            req_credit <= req_pop; // One credit back per popped command.
            if (req_push) begin
                req_wr_ptr <= (req_wr_ptr == REQ_AW'(`RNG_REQ_DEPTH - 1)) ? '0
                                                                          : req_wr_ptr + 1'b1;
            end
            if (req_pop) begin
                req_rd_ptr <= (req_rd_ptr == REQ_AW'(`RNG_REQ_DEPTH - 1)) ? '0
                                                                          : req_rd_ptr + 1'b1;
            end
            if (req_push && !req_pop) begin
                req_count <= req_count + credit_t'(1);
            end else if (!req_push && req_pop) begin
                req_count <= req_count - credit_t'(1);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response FIFO of generated words.
    logic       [31:0] rsp_mem [`RNG_RSP_DEPTH];
    logic [RSP_AW-1:0] rsp_wr_ptr;
    logic [RSP_AW-1:0] rsp_rd_ptr;
    credit_t           rsp_count;
    credit_t           rsp_credits;
    logic              rsp_push;
    logic              rsp_pop;

    // A draw needs a free response slot before it may ask for the generator.
    assign arb_req = (req_count != '0)
                  && ((arb_op == OP_SEED) || (rsp_count != credit_t'(`RNG_RSP_DEPTH)));

    assign rsp_push  = grant && (arb_op == OP_NEXT);
    assign rsp_valid = (rsp_count != '0) && (rsp_credits != '0);
    assign rsp_pop   = rsp_valid;
    assign rsp_data  = rsp_mem[rsp_rd_ptr];

    always_ff @(posedge clock) begin
        if (rsp_push) begin
            rsp_mem[rsp_wr_ptr] <= next_value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rsp_wr_ptr  <= '0;
            rsp_rd_ptr  <= '0;
            rsp_count   <= '0;
            rsp_credits <= credit_t'(`RNG_RSP_CREDITS);
        end else begin
            if (rsp_push) begin
                rsp_wr_ptr <= (rsp_wr_ptr == RSP_AW'(`RNG_RSP_DEPTH - 1)) ? '0
                                                                          : rsp_wr_ptr + 1'b1;
            end
            if (rsp_pop) begin
                rsp_rd_ptr <= (rsp_rd_ptr == RSP_AW'(`RNG_RSP_DEPTH - 1)) ? '0
                                                                          : rsp_rd_ptr + 1'b1;
            end
            if (rsp_push && !rsp_pop) begin
                rsp_count <= rsp_count + credit_t'(1);
            end else if (!rsp_push && rsp_pop) begin
                rsp_count <= rsp_count - credit_t'(1);
            end
            if (rsp_pop && !rsp_credit) begin
                rsp_credits <= rsp_credits - credit_t'(1); // Word sent.
            end else if (!rsp_pop && rsp_credit) begin
                rsp_credits <= rsp_credits + credit_t'(1); // Client slot freed.
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rng_hub.sv
// Top of the shared RNG service, wiring the client channels, the arbiter and the LCG core.
`timescale 1ns/100ps
`default_nettype none

`include "rng_defs.svh"

module rng_hub (
    input  wire logic                                         clock,
    input  wire logic                                         reset,
    input  wire logic                [`RNG_NUM_CHANNELS-1:0]  req_valid,
    input  wire rng_op_pkg::rng_op_t [`RNG_NUM_CHANNELS-1:0]  req_op,
    input  wire logic [`RNG_NUM_CHANNELS-1:0][31:0]           req_seed,
    output logic                     [`RNG_NUM_CHANNELS-1:0]  req_credit,
    output logic                     [`RNG_NUM_CHANNELS-1:0]  rsp_valid,
    output logic [`RNG_NUM_CHANNELS-1:0][31:0]                rsp_data,
    input  wire logic                [`RNG_NUM_CHANNELS-1:0]  rsp_credit
);

    import rng_op_pkg::*;

    logic    [`RNG_NUM_CHANNELS-1:0]       arb_req;
    rng_op_t [`RNG_NUM_CHANNELS-1:0]       arb_op;
    logic    [`RNG_NUM_CHANNELS-1:0][31:0] arb_seed;
    logic    [`RNG_NUM_CHANNELS-1:0]       grant;
    logic                                  step;
    logic                                  load;
    logic    [31:0]                        load_value;
    logic    [31:0]                        next_value;

    for (genvar c = 0; c < `RNG_NUM_CHANNELS; c++) begin : gen_channel
        rng_channel i_channel (
            .clock      (clock),
            .reset      (reset),
            .req_valid  (req_valid[c]),
            .req_op     (req_op[c]),
            .req_seed   (req_seed[c]),
            .req_credit (req_credit[c]),
            .rsp_valid  (rsp_valid[c]),
            .rsp_data   (rsp_data[c]),
            .rsp_credit (rsp_credit[c]),
            .arb_req    (arb_req[c]),
            .arb_op     (arb_op[c]),
            .arb_seed   (arb_seed[c]),
            .grant      (grant[c]),
            .next_value (next_value) // Shared word, only the granted channel keeps it.
        );
    end

    rng_arbiter i_arbiter (
        .clock      (clock),
        .reset      (reset),
        .arb_req    (arb_req),
        .arb_op     (arb_op),
        .arb_seed   (arb_seed),
        .grant      (grant),
        .step       (step),
        .load       (load),
        .load_value (load_value)
    );

    lcg_core i_core (
        .clock      (clock),
        .reset      (reset),
        .step       (step),
        .load       (load),
        .load_value (load_value),
        .next_value (next_value)
    );

endmodule

`default_nettype wire

//--- verif/tb_rng_hub_checks.svh
// Compare tasks of the RNG hub testbench, included into the body of its top module.
`ifndef TB_RNG_HUB_CHECKS_SVH
`define TB_RNG_HUB_CHECKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Generated words.
task automatic check_word(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
        abort_run();
    end
endtask

// Word, credit and FIFO counts.
task automatic check_op_count(input string name, input credit_t got, input credit_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        abort_run();
    end
endtask

// Channel a response came back on.
task automatic check_order(input string name, input chan_idx_t got, input chan_idx_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        abort_run();
    end
endtask

`endif

//--- verif/tb_rng_hub.sv
// Testbench for the RNG hub, driven block by block from the case file; run from the project root.
`timescale 1ns/100ps
`default_nettype none

`include "rng_defs.svh"

module tb_rng_hub;

    import rng_op_pkg::*;
    import rng_ctrl_pkg::*;

    localparam int          N          = `RNG_NUM_CHANNELS;
    localparam int          REC        = 9; // Words per case block.
    localparam logic [31:0] KIND_SEED  = 32'h1;
    localparam logic [31:0] KIND_DRAW  = 32'h2;
    localparam logic [31:0] KIND_DRAIN = 32'h3;
    localparam logic [31:0] KIND_END   = 32'hf;

    logic                  clock;
    logic                  reset;
    logic    [N-1:0]       req_valid;
    rng_op_t [N-1:0]       req_op;
    logic    [N-1:0][31:0] req_seed;
    logic    [N-1:0]       req_credit;
    logic    [N-1:0]       rsp_valid;
    logic    [N-1:0][31:0] rsp_data;
    logic    [N-1:0]       rsp_credit;

    logic [31:0] cases [256];
    logic [31:0] rx_word [N][16];
    int          rx_count [N];
    int          free_pending [N]; // Client slots waiting to be returned.
    int          hold_left [N];
    credit_t     req_credits [N];
    credit_t     rsp_credits [N];
    logic        hold_mode;
    logic [31:0] model_state;
    logic [31:0] lfsr_state = 32'h33ec;
    int          case_words = 0;

    rng_hub i_dut (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_seed   (req_seed),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_credit (rsp_credit)
    );

    `include "tb_rng_hub_checks.svh"

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    // Galois LFSR, one step per bit taken.
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return `RNG_LCG_A * x + `RNG_LCG_C;
    endfunction

    function automatic int words_received();
        int sum;
        sum = 0;
        for (int c = 0; c < N; c++) begin
            sum += rx_count[c];
        end
        return sum;
    endfunction

    function automatic logic all_idle();
        logic idle;
        idle = 1'b1;
        for (int c = 0; c < N; c++) begin
            if (free_pending[c] != 0 || req_credits[c] != credit_t'(`RNG_REQ_DEPTH)) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Client side monitor, sampled mid-cycle.
    always @(negedge clock) begin
        if (!reset) begin
            for (int c = 0; c < N; c++) begin
                if (req_credit[c]) begin
                    if (req_credits[c] == credit_t'(`RNG_REQ_DEPTH)) begin
                        report_error($sformatf("extra req_credit pulse on channel %0d", c));
                    end
                    req_credits[c] = req_credits[c] + credit_t'(1);
                end
                if (rsp_valid[c]) begin
                    if (rsp_credits[c] == '0) begin
                        report_error($sformatf("rsp_valid without a credit on channel %0d", c));
                    end
                    if (rx_count[c] == 16) begin
                        report_error($sformatf("too many words on channel %0d", c));
                    end
                    rsp_credits[c]            = rsp_credits[c] - credit_t'(1);
                    rx_word[c][rx_count[c]]   = rsp_data[c];
                    rx_count[c]               = rx_count[c] + 1;
                    free_pending[c]           = free_pending[c] + 1;
                end
            end
        end
    end

    // Steps one cycle and hands back freed response slots.
    task automatic next_cycle();
        @(posedge clock);
        #2;
        req_valid  = '0;
        rsp_credit = '0;
        for (int c = 0; c < N; c++) begin
            if (free_pending[c] > 0 && hold_left[c] > 0) begin
                hold_left[c] = hold_left[c] - 1;
            end else if (free_pending[c] > 0) begin
                rsp_credit[c]   = 1'b1;
                free_pending[c] = free_pending[c] - 1;
                rsp_credits[c]  = rsp_credits[c] + credit_t'(1);
                hold_left[c]    = hold_mode ? random_bits(4) : 0;
            end
        end
    endtask

    task automatic send_command(input int c, input rng_op_t op, input logic [31:0] seed);
        req_valid[c]   = 1'b1;
        req_op[c]      = op;
        req_seed[c]    = seed;
        req_credits[c] = req_credits[c] - credit_t'(1);
    endtask

    task automatic wait_credit(input int c);
        next_cycle();
        while (req_credits[c] == '0) begin
            next_cycle();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Case blocks.
    task automatic draw_words(input int base);
        int          left [N];
        int          last [N];
        logic [31:0] pool [32];
        logic        used [32];
        int          total;
        int          idx;
        total     = int'(cases[base+3]);
        hold_mode = cases[base+4][0];
        if (total > 32) begin
            report_error("draw block asks for more than 32 words");
        end
        for (int i = 0; i < total; i++) begin
            model_state = lcg_next(model_state);
            pool[i]     = model_state;
            used[i]     = 1'b0;
        end
        for (int c = 0; c < N; c++) begin
            left[c]     = int'(cases[base+5+c]);
            last[c]     = -1;
            rx_count[c] = 0;
        end
        while (words_received() < total) begin
            next_cycle();
            for (int c = 0; c < N; c++) begin
                if (left[c] > 0 && req_credits[c] != '0 && random_bits(1) == 1) begin
                    send_command(c, OP_NEXT, '0);
                    left[c] = left[c] - 1;
                end
            end
        end
        for (int c = 0; c < N; c++) begin
            check_op_count($sformatf("words on channel %0d", c), credit_t'(rx_count[c]),
                           credit_t'(cases[base+5+c]));
            for (int k = 0; k < rx_count[c]; k++) begin
                idx = -1;
                for (int i = total - 1; i > last[c]; i--) begin
                    if (!used[i] && pool[i] == rx_word[c][k]) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    idx = last[c] + 1;
                    while (idx < total && used[idx]) begin
                        idx++;
                    end
                    if (idx == total) begin
                        report_error($sformatf("channel %0d got a word past the sequence", c));
                    end
                    check_word($sformatf("rsp_data[%0d]", c), rx_word[c][k], pool[idx]);
                end
                used[idx] = 1'b1;
                last[c]   = idx; // Later words on this channel must come later in the sequence.
            end
        end
    endtask

    task automatic load_seed(input int base);
        chan_idx_t   ch;
        chan_idx_t   probe;
        chan_idx_t   got_ch;
        logic [31:0] expected;
        ch        = chan_idx_t'(cases[base+1]);
        probe     = chan_idx_t'(random_bits(2));
        expected  = lcg_next(cases[base+2]); // First word after the new state.
        hold_mode = 1'b0;
        wait_credit(int'(ch));
        send_command(int'(ch), OP_SEED, cases[base+2]);
        while (req_credits[ch] != credit_t'(`RNG_REQ_DEPTH)) begin
            next_cycle();
        end
        for (int c = 0; c < N; c++) begin
            rx_count[c] = 0;
        end
        wait_credit(int'(probe));
        send_command(int'(probe), OP_NEXT, '0);
        while (words_received() == 0) begin
            next_cycle();
        end
        got_ch = probe;
        for (int c = 0; c < N; c++) begin
            if (rx_count[c] != 0) begin
                got_ch = chan_idx_t'(c);
            end
        end
        check_order("rsp_valid channel", got_ch, probe);
        check_word("rsp_data", rx_word[got_ch][0], expected);
        model_state = expected;
    endtask

    task automatic drain_traffic();
        int waited;
        hold_mode = 1'b0;
        waited    = 0;
        next_cycle();
        while (!all_idle() && waited < 64) begin
            next_cycle();
            waited++;
        end
        for (int c = 0; c < N; c++) begin
            check_op_count($sformatf("request credits on channel %0d", c), req_credits[c],
                           credit_t'(`RNG_REQ_DEPTH));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        wait (case_words > 0);
        repeat (200 * case_words + 500) @(posedge clock);
        report_error($sformatf("run did not end within %0d cycles", 200 * case_words + 500));
    end

    initial begin
        int pos;
        reset       = 1'b1;
        req_valid   = '0;
        req_seed    = '0;
        rsp_credit  = '0;
        hold_mode   = 1'b0;
        model_state = `RNG_RESET_SEED;
        for (int c = 0; c < N; c++) begin
            req_op[c]       = OP_NEXT;
            rx_count[c]     = 0;
            free_pending[c] = 0;
            hold_left[c]    = 0;
            req_credits[c]  = credit_t'(`RNG_REQ_DEPTH);
            rsp_credits[c]  = credit_t'(`RNG_RSP_CREDITS);
        end
        $readmemh("verif/rng_hub_cases.txt", cases);
        pos = 0;
        while (pos < 247 && cases[pos] !== KIND_END) begin
            pos += REC;
        end
        case_words = pos + REC;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        pos   = 0;
        while (cases[pos] !== KIND_END) begin
            case (cases[pos])
                KIND_SEED:  load_seed(pos);
                KIND_DRAW:  draw_words(pos);
                KIND_DRAIN: drain_traffic();
                default:    report_error($sformatf("unknown block kind at word %0d", pos));
            endcase
            pos += REC;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rng_hub_cases.txt
// kind chan seed expect hold n0 n1 n2 n3 (hex), one block per line.
// kind 1 seed (expect = first word after it), 2 draw (expect = total words), 3 drain, f end.
2 0 00000000 00000005 0 5 0 0 0
3 0 00000000 00000000 0 0 0 0 0
2 0 00000000 0000000c 0 3 3 3 3
3 0 00000000 00000000 0 0 0 0 0
1 2 00000000 3c6ef35f 0 0 0 0 0
2 0 00000000 00000010 1 4 4 4 4
3 0 00000000 00000000 0 0 0 0 0
1 1 00000001 3c88596c 0 0 0 0 0
2 0 00000000 0000000e 1 7 0 2 5
3 0 00000000 00000000 0 0 0 0 0
1 3 ffffffff 3c558d52 0 0 0 0 0
2 0 00000000 0000000a 0 1 2 3 4
3 0 00000000 00000000 0 0 0 0 0
1 0 00010000 a27bf35f 0 0 0 0 0
2 0 00000000 00000006 1 0 6 0 0
3 0 00000000 00000000 0 0 0 0 0
1 2 00000002 3ca21f79 0 0 0 0 0
3 0 00000000 00000000 0 0 0 0 0
f 0 00000000 00000000 0 0 0 0 0

//--- rng_hub.f
+incdir+design
+incdir+verif
design/rng_op_pkg.sv
design/rng_ctrl_pkg.sv
design/lcg_mul_lo.sv
design/lcg_core.sv
design/rng_arbiter.sv
design/rng_channel.sv
design/rng_hub.sv
verif/tb_rng_hub.sv

//--- Makefile
SIM := obj_dir/Vtb_rng_hub

$(SIM): rng_hub.f $(wildcard design/*.sv design/*.svh verif/*.sv verif/*.svh)
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_rng_hub -f rng_hub.f

run: $(SIM) verif/rng_hub_cases.txt
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
